//--- safe_domain_pkg.sv
package safe_domain_pkg;

        // ************************************************************
        // Pad bank dimensions
        // ************************************************************

        localparam int unsigned N_PADS     = 8;
        localparam int unsigned PAD_CFG_W  = 6;
        localparam int unsigned PAD_MUX_W  = 2;
        localparam int unsigned N_SPI_DATA = 4;

        // Reference cycles per slow clock period, keep this even
        localparam int unsigned SLOW_CLK_DIV = 4;

        // Fixed pad positions of the peripheral signals
        localparam int PAD_SPI_SDIO0 = 0;
        localparam int PAD_SPI_CSN0  = 4;
        localparam int PAD_SPI_SCK   = 5;
        localparam int PAD_UART_TX   = 6;
        localparam int PAD_UART_RX   = 7;

        typedef logic [N_PADS-1:0]               pad_vec_t;
        typedef logic [PAD_CFG_W-1:0]            pad_cfg_t;
        typedef logic [PAD_MUX_W-1:0]            pad_mux_t;
        typedef logic [N_SPI_DATA-1:0]           spi_data_t;
        typedef logic [$clog2(SLOW_CLK_DIV)-1:0] slow_cnt_t;

        // Last count of each slow clock half period
        localparam slow_cnt_t SLOW_CNT_LAST = slow_cnt_t'(SLOW_CLK_DIV / 2 - 1);

        // Per-pad function codes
        localparam pad_mux_t PAD_FN_GPIO = 2'd0;
        localparam pad_mux_t PAD_FN_ALT  = 2'd1;
        localparam pad_mux_t PAD_FN_OFF0 = 2'd2;
        localparam pad_mux_t PAD_FN_OFF1 = 2'd3;

        // Bit positions in the decoded route
        localparam int RT_GPIO = 0;
        localparam int RT_ALT  = 1;

        // Level seen by the UART receiver when pad 7 is not routed
        localparam logic UART_IDLE = 1'b1;

        // Function select decode shared by the output and input paths
        function automatic logic [1:0] pad_fn_decode(input pad_mux_t sel);
                logic [1:0] route;
                route = 2'b00;
                case (sel)
                        PAD_FN_GPIO:              route[RT_GPIO] = 1'b1;
                        PAD_FN_ALT:               route[RT_ALT]  = 1'b1;
                        PAD_FN_OFF0, PAD_FN_OFF1: route = 2'b00;
                endcase
                return route;
        endfunction

endpackage

//--- rst_sync.sv
`timescale 1ns/1ps

module rst_sync
(
        input  logic ref_clk_i,
        input  logic arst_n_i,
        output logic rst_n_o
);

        // Synchronizer chain, bit 1 is the released reset
        logic [1:0] sync_q;

        // ************************************************************
        // Assert at once, release on the second clock edge
        // ************************************************************

        always_ff @(posedge ref_clk_i or negedge arst_n_i)
        begin
                if (!arst_n_i)
                begin
                        sync_q <= 2'b00;
                end
                else
                begin
                        sync_q <= {sync_q[0], 1'b1};
                end
        end

        assign rst_n_o = sync_q[1];

endmodule

//--- slow_clk_gen.sv
`timescale 1ns/1ps

module slow_clk_gen import safe_domain_pkg::*;
(
        input  logic ref_clk_i,
        input  logic rst_n_i,
        output logic slow_clk_o
);

        slow_cnt_t cnt_q;
        logic      slow_clk_q;

        // ************************************************************
        // Half period counter
        // ************************************************************

        // The output toggles when the counter wraps, so each half
        // period lasts SLOW_CLK_DIV/2 reference cycles
        always_ff @(posedge ref_clk_i or negedge rst_n_i)
        begin
                if (!rst_n_i)
                begin
                        cnt_q      <= '0;
                        slow_clk_q <= 1'b0;
                end
                else if (cnt_q == SLOW_CNT_LAST)
                begin
                        cnt_q      <= '0;
                        slow_clk_q <= ~slow_clk_q;
                end
                else
                begin
                        cnt_q <= cnt_q + slow_cnt_t'(1);
                end
        end

        // Straight from a flop, no glitches on the divided clock
        assign slow_clk_o = slow_clk_q;

endmodule

//--- pad_out_mux.sv
`timescale 1ns/1ps

module pad_out_mux import safe_domain_pkg::*;
(
        input  pad_mux_t [N_PADS-1:0] pad_sel_i,
        input  pad_cfg_t [N_PADS-1:0] pad_cfg_i,
        input  pad_cfg_t [N_PADS-1:0] gpio_cfg_i,

        input  pad_vec_t              gpio_out_i,
        input  pad_vec_t              gpio_dir_i,

        input  spi_data_t             spi_sdo_i,
        input  spi_data_t             spi_oen_i,
        input  logic                  spi_clk_i,
        input  logic                  spi_csn_i,
        input  logic                  uart_tx_i,

        output pad_vec_t              pad_out_o,
        output pad_vec_t              pad_oe_o,
        output pad_cfg_t [N_PADS-1:0] pad_cfg_o
);

        genvar k;

        generate
                for (k = 0; k < N_PADS; k++)
                begin : g_pad
                        logic       alt_out;
                        logic       alt_oe;
                        logic [1:0] route;

                        // ****************************************************
                        // Alternate function of this pad
                        // ****************************************************

                        if (k >= PAD_SPI_SDIO0 && k < PAD_SPI_SDIO0 + N_SPI_DATA)
                        begin : g_spi_data
                                // SPI data line, enable is active low on the master side
                                assign alt_out = spi_sdo_i[k - PAD_SPI_SDIO0];
                                assign alt_oe  = ~spi_oen_i[k - PAD_SPI_SDIO0];
                        end
                        else if (k == PAD_SPI_CSN0)
                        begin : g_spi_csn
                                assign alt_out = spi_csn_i;
                                assign alt_oe  = 1'b1;
                        end
                        else if (k == PAD_SPI_SCK)
                        begin : g_spi_sck
                                assign alt_out = spi_clk_i;
                                assign alt_oe  = 1'b1;
                        end
                        else if (k == PAD_UART_TX)
                        begin : g_uart_tx
                                assign alt_out = uart_tx_i;
                                assign alt_oe  = 1'b1;
                        end
                        else if (k == PAD_UART_RX)
                        begin : g_uart_rx
                                // Input only, the driver stays off
                                assign alt_out = 1'b0;
                                assign alt_oe  = 1'b0;
                        end
                        else
                        begin : g_no_alt
                                assign alt_out = 1'b0;
                                assign alt_oe  = 1'b0;
                        end

                        // ****************************************************
                        // Function select
                        // ****************************************************

                        assign route = pad_fn_decode(pad_sel_i[k]);

                        // Disabled pads fall through to 0
                        assign pad_out_o[k] = route[RT_GPIO] ? gpio_out_i[k] :
                                              route[RT_ALT]  ? alt_out       : 1'b0;
                        assign pad_oe_o[k]  = route[RT_GPIO] ? gpio_dir_i[k] :
                                              route[RT_ALT]  ? alt_oe        : 1'b0;

                        // GPIO has its own electrical setup, all other
                        // modes take the pad control register
                        assign pad_cfg_o[k] = route[RT_GPIO] ? gpio_cfg_i[k] : pad_cfg_i[k];
                end
        endgenerate

endmodule

//--- pad_in_demux.sv
`timescale 1ns/1ps

module pad_in_demux import safe_domain_pkg::*;
(
        input  pad_mux_t [N_PADS-1:0] pad_sel_i,
        input  pad_vec_t              pad_in_i,

        output pad_vec_t              gpio_in_o,
        output spi_data_t             spi_sdi_o,
        output logic                  uart_rx_o
);

        // Decoded routes, one bit per pad
        pad_vec_t gpio_sel;
        pad_vec_t alt_sel;

        genvar k;
        genvar i;

        // ************************************************************
        // Route decode
        // ************************************************************

        generate
                for (k = 0; k < N_PADS; k++)
                begin : g_decode
                        logic [1:0] route;

                        assign route       = pad_fn_decode(pad_sel_i[k]);
                        assign gpio_sel[k] = route[RT_GPIO];
                        assign alt_sel[k]  = route[RT_ALT];
                end
        endgenerate

        // ************************************************************
        // Receivers
        // ************************************************************

        // GPIO reads 0 on pads owned by another function
        assign gpio_in_o = pad_in_i & gpio_sel;

        generate
                for (i = 0; i < N_SPI_DATA; i++)
                begin : g_spi_sdi
                        assign spi_sdi_o[i] = alt_sel[PAD_SPI_SDIO0 + i] ?
                                              pad_in_i[PAD_SPI_SDIO0 + i] : 1'b0;
                end
        endgenerate

        // Unrouted UART line looks idle to the receiver
        assign uart_rx_o = alt_sel[PAD_UART_RX] ? pad_in_i[PAD_UART_RX] : UART_IDLE;

endmodule

//--- safe_domain.sv
`timescale 1ns/1ps

module safe_domain import safe_domain_pkg::*;
(
        input  logic                          ref_clk_i,
        input  logic                          arst_n_i,
        output logic                          rst_n_o,
        output logic                          slow_clk_o,

        // Pad control register
        input  logic [N_PADS*PAD_MUX_W-1:0]   pad_mux_i,
        input  logic [N_PADS*PAD_CFG_W-1:0]   pad_cfg_i,
        output pad_cfg_t [N_PADS-1:0]         pad_cfg_o,

        // GPIO
        input  pad_vec_t                      gpio_out_i,
        input  pad_vec_t                      gpio_dir_i,
        input  logic [N_PADS*PAD_CFG_W-1:0]   gpio_cfg_i,
        output pad_vec_t                      gpio_in_o,

        // SPI master
        input  logic                          spi_clk_i,
        input  logic                          spi_csn_i,
        input  spi_data_t                     spi_sdo_i,
        input  spi_data_t                     spi_oen_i,
        output spi_data_t                     spi_sdi_o,

        // UART
        input  logic                          uart_tx_i,
        output logic                          uart_rx_o,

        // Pad frame
        input  pad_vec_t                      pad_in_i,
        output pad_vec_t                      pad_out_o,
        output pad_vec_t                      pad_oe_o
);

        pad_mux_t [N_PADS-1:0] pad_sel;
        pad_cfg_t [N_PADS-1:0] pad_cfg;
        pad_cfg_t [N_PADS-1:0] gpio_cfg;

        genvar k;

        // ************************************************************
        // Unpack the flat configuration buses, pad 0 in the low bits
        // ************************************************************

        generate
                for (k = 0; k < N_PADS; k++)
                begin : g_unpack
                        assign pad_sel[k]  = pad_mux_i[k*PAD_MUX_W +: PAD_MUX_W];
                        assign pad_cfg[k]  = pad_cfg_i[k*PAD_CFG_W +: PAD_CFG_W];
                        assign gpio_cfg[k] = gpio_cfg_i[k*PAD_CFG_W +: PAD_CFG_W];
                end
        endgenerate

        // ************************************************************
        // Reset and slow clock
        // ************************************************************

        rst_sync i_rst_sync
        (
                .ref_clk_i  ( ref_clk_i  ),
                .arst_n_i   ( arst_n_i   ),
                .rst_n_o    ( rst_n_o    )
        );

        // Divider starts from the synchronized reset
        slow_clk_gen i_slow_clk_gen
        (
                .ref_clk_i  ( ref_clk_i  ),
                .rst_n_i    ( rst_n_o    ),
                .slow_clk_o ( slow_clk_o )
        );

        // ************************************************************
        // Pad routing
        // ************************************************************

        pad_out_mux i_pad_out_mux
        (
                .pad_sel_i  ( pad_sel    ),
                .pad_cfg_i  ( pad_cfg    ),
                .gpio_cfg_i ( gpio_cfg   ),
                .gpio_out_i ( gpio_out_i ),
                .gpio_dir_i ( gpio_dir_i ),
                .spi_sdo_i  ( spi_sdo_i  ),
                .spi_oen_i  ( spi_oen_i  ),
                .spi_clk_i  ( spi_clk_i  ),
                .spi_csn_i  ( spi_csn_i  ),
                .uart_tx_i  ( uart_tx_i  ),
                .pad_out_o  ( pad_out_o  ),
                .pad_oe_o   ( pad_oe_o   ),
                .pad_cfg_o  ( pad_cfg_o  )
        );

        pad_in_demux i_pad_in_demux
        (
                .pad_sel_i  ( pad_sel    ),
                .pad_in_i   ( pad_in_i   ),
                .gpio_in_o  ( gpio_in_o  ),
                .spi_sdi_o  ( spi_sdi_o  ),
                .uart_rx_o  ( uart_rx_o  )
        );

endmodule

//--- safe_domain_checker.sv
`timescale 1ns/1ps

module safe_domain_checker import safe_domain_pkg::*;
(
        input  logic                        ref_clk_i,
        input  logic                        arst_n_i,
        input  logic                        rst_n_o,
        input  logic                        slow_clk_o,
        input  logic [N_PADS*PAD_MUX_W-1:0] pad_mux_i,
        input  logic [N_PADS*PAD_CFG_W-1:0] pad_cfg_i,
        input  logic [N_PADS*PAD_CFG_W-1:0] gpio_cfg_i,
        input  pad_vec_t                    gpio_out_i,
        input  pad_vec_t                    gpio_dir_i,
        input  logic                        spi_clk_i,
        input  logic                        spi_csn_i,
        input  spi_data_t                   spi_sdo_i,
        input  spi_data_t                   spi_oen_i,
        input  logic                        uart_tx_i,
        input  pad_vec_t                    pad_in_i,
        input  logic [N_PADS*PAD_CFG_W-1:0] pad_cfg_o,
        input  pad_vec_t                    gpio_in_o,
        input  spi_data_t                   spi_sdi_o,
        input  logic                        uart_rx_o,
        input  pad_vec_t                    pad_out_o,
        input  pad_vec_t                    pad_oe_o,
        output int                          err_count_o
);

        // Rising edges seen since arst_n_i went high
        int edges;

        initial
        begin
                err_count_o = 0;
                edges       = 0;
        end

        task automatic compare_hex(input string name, input logic [63:0] exp,
                                   input logic [63:0] act);
                if (exp !== act)
                begin
                        err_count_o++;
                        $display("ERROR: %s expected %h actual %h at %0t", name, exp, act, $time);
                end
        endtask

        // ************************************************************
        // Reference model of the pad routing rules
        // ************************************************************

        always @(posedge ref_clk_i)
        begin
                logic [1:0]                  sel;
                pad_vec_t                    e_out;
                pad_vec_t                    e_oe;
                pad_vec_t                    e_gin;
                spi_data_t                   e_sdi;
                logic                        e_urx;
                logic [N_PADS*PAD_CFG_W-1:0] e_cfg;
                logic                        e_rst;
                logic                        e_slow;

                edges = arst_n_i ? edges + 1 : 0;
                #1;
                e_out = '0;
                e_oe  = '0;
                e_gin = '0;
                e_sdi = '0;
                e_urx = 1'b1;
                e_cfg = pad_cfg_i;
                for (int k = 0; k < N_PADS; k++)
                begin
                        sel = pad_mux_i[k*PAD_MUX_W +: PAD_MUX_W];
                        if (sel == PAD_FN_GPIO)
                        begin
                                e_out[k] = gpio_out_i[k];
                                e_oe[k]  = gpio_dir_i[k];
                                e_gin[k] = pad_in_i[k];
                                e_cfg[k*PAD_CFG_W +: PAD_CFG_W] = gpio_cfg_i[k*PAD_CFG_W +: PAD_CFG_W];
                        end
                        else if (sel == PAD_FN_ALT)
                        begin
                                if (k < PAD_SPI_SDIO0 + N_SPI_DATA)
                                begin
                                        e_out[k] = spi_sdo_i[k - PAD_SPI_SDIO0];
                                        e_oe[k]  = !spi_oen_i[k - PAD_SPI_SDIO0];
                                        e_sdi[k - PAD_SPI_SDIO0] = pad_in_i[k];
                                end
                                else if (k == PAD_SPI_CSN0)
                                        {e_out[k], e_oe[k]} = {spi_csn_i, 1'b1};
                                else if (k == PAD_SPI_SCK)
                                        {e_out[k], e_oe[k]} = {spi_clk_i, 1'b1};
                                else if (k == PAD_UART_TX)
                                        {e_out[k], e_oe[k]} = {uart_tx_i, 1'b1};
                                else
                                        e_urx = pad_in_i[PAD_UART_RX];
                        end
                end

                // Reset rises on the second edge, slow clock starts low for two cycles
                e_rst  = (edges >= 2);
                e_slow = e_rst ? (((edges - 2) / 2) % 2 == 1) : 1'b0;

                compare_hex("rst_n_o", 64'(e_rst), 64'(rst_n_o));
                compare_hex("slow_clk_o", 64'(e_slow), 64'(slow_clk_o));
                compare_hex("pad_out_o", 64'(e_out), 64'(pad_out_o));
                compare_hex("pad_oe_o", 64'(e_oe), 64'(pad_oe_o));
                compare_hex("pad_cfg_o", 64'(e_cfg), 64'(pad_cfg_o));
                compare_hex("gpio_in_o", 64'(e_gin), 64'(gpio_in_o));
                compare_hex("spi_sdi_o", 64'(e_sdi), 64'(spi_sdi_o));
                compare_hex("uart_rx_o", 64'(e_urx), 64'(uart_rx_o));
        end

endmodule

//--- safe_domain_assert.sv
`timescale 1ns/1ps

module safe_domain_assert
(
        input logic ref_clk_i,
        input logic arst_n_i,
        input logic rst_n_o,
        input logic slow_clk_o
);

        // Synchronized reset is low whenever the chip reset is low
        a_rst_follows: assert property (@(posedge ref_clk_i) !arst_n_i |-> !rst_n_o)
                else $error("rst_n_o high while arst_n_i is low");

        // Release lands on the second rising edge
        a_rst_release: assert property (@(posedge ref_clk_i)
                $rose(arst_n_i) |-> !rst_n_o ##1 !rst_n_o ##1 rst_n_o)
                else $error("rst_n_o released on the wrong edge");

        a_slow_in_reset: assert property (@(posedge ref_clk_i) !rst_n_o |-> !slow_clk_o)
                else $error("slow_clk_o high during reset");

        // Two cycles high, two low, then high again
        a_slow_period: assert property (@(posedge ref_clk_i) disable iff (!rst_n_o)
                $rose(slow_clk_o) |-> slow_clk_o ##1 slow_clk_o ##1 !slow_clk_o
                ##1 !slow_clk_o ##1 slow_clk_o)
                else $error("slow_clk_o period is not four reference cycles");

endmodule

bind safe_domain safe_domain_assert u_safe_domain_assert
(
        .ref_clk_i  ( ref_clk_i  ),
        .arst_n_i   ( arst_n_i   ),
        .rst_n_o    ( rst_n_o    ),
        .slow_clk_o ( slow_clk_o )
);

//--- tb_safe_domain.sv
`timescale 1ns/1ps

module tb_safe_domain;

        localparam int CLK_PERIOD = 8;
        localparam int RST_CYCLES = 8;
        localparam int N_DIRECTED = 6;
        localparam int N_RANDOM   = 8;
        localparam int N_ROWS     = N_DIRECTED + 3 * N_RANDOM;

        typedef struct packed {
                logic [15:0] mux;
                logic [47:0] pcfg;
                logic [47:0] gcfg;
                logic [7:0]  gout;
                logic [7:0]  gdir;
                logic [7:0]  pin;
                logic [3:0]  sdo;
                logic [3:0]  oen;
                logic        sclk;
                logic        csn;
                logic        utx;
        } stim_t;

        logic        ref_clk;
        logic        arst_n;
        logic        rst_n;
        logic        slow_clk;
        logic [15:0] pad_mux;
        logic [47:0] pad_cfg;
        logic [47:0] gpio_cfg;
        logic [7:0]  gpio_out;
        logic [7:0]  gpio_dir;
        logic        spi_clk;
        logic        spi_csn;
        logic [3:0]  spi_sdo;
        logic [3:0]  spi_oen;
        logic        uart_tx;
        logic [7:0]  pad_in;
        logic [47:0] pad_cfg_out;
        logic [7:0]  gpio_in;
        logic [3:0]  spi_sdi;
        logic        uart_rx;
        logic [7:0]  pad_out;
        logic [7:0]  pad_oe;
        int          err_count;
        stim_t       rows [N_ROWS];

        safe_domain DUT
        (
                .ref_clk_i (ref_clk), .arst_n_i (arst_n), .rst_n_o (rst_n),
                .slow_clk_o (slow_clk), .pad_mux_i (pad_mux), .pad_cfg_i (pad_cfg),
                .pad_cfg_o (pad_cfg_out), .gpio_out_i (gpio_out), .gpio_dir_i (gpio_dir),
                .gpio_cfg_i (gpio_cfg), .gpio_in_o (gpio_in), .spi_clk_i (spi_clk),
                .spi_csn_i (spi_csn), .spi_sdo_i (spi_sdo), .spi_oen_i (spi_oen),
                .spi_sdi_o (spi_sdi), .uart_tx_i (uart_tx), .uart_rx_o (uart_rx),
                .pad_in_i (pad_in), .pad_out_o (pad_out), .pad_oe_o (pad_oe)
        );

        safe_domain_checker u_checker
        (
                .ref_clk_i (ref_clk), .arst_n_i (arst_n), .rst_n_o (rst_n),
                .slow_clk_o (slow_clk), .pad_mux_i (pad_mux), .pad_cfg_i (pad_cfg),
                .gpio_cfg_i (gpio_cfg), .gpio_out_i (gpio_out), .gpio_dir_i (gpio_dir),
                .spi_clk_i (spi_clk), .spi_csn_i (spi_csn), .spi_sdo_i (spi_sdo),
                .spi_oen_i (spi_oen), .uart_tx_i (uart_tx), .pad_in_i (pad_in),
                .pad_cfg_o (pad_cfg_out), .gpio_in_o (gpio_in), .spi_sdi_o (spi_sdi),
                .uart_rx_o (uart_rx), .pad_out_o (pad_out), .pad_oe_o (pad_oe),
                .err_count_o (err_count)
        );

        initial ref_clk = 1'b0;
        always #(CLK_PERIOD / 2) ref_clk = ~ref_clk;

        function automatic stim_t random_row(input logic [15:0] mux);
                stim_t r;
                r      = stim_t'({$urandom(), $urandom(), $urandom(), $urandom(), $urandom()});
                r.mux  = mux;
                r.pcfg = 48'({$urandom(), $urandom()});
                r.gcfg = 48'({$urandom(), $urandom()});
                return r;
        endfunction

        // ************************************************************
        // Stimulus table
        // ************************************************************

        task automatic build_table();
                int idx;
                // All GPIO, all ALT, all OFF0, all OFF1, ALT with mixed enables, mixed
                rows[0] = {16'h0000, 48'h0123_4567_89ab, 48'hba98_7654_3210,
                           8'hA5, 8'h3C, 8'h96, 4'h9, 4'h0, 1'b1, 1'b0, 1'b1};
                rows[1] = {16'h5555, 48'h0123_4567_89ab, 48'hba98_7654_3210,
                           8'hA5, 8'h3C, 8'h96, 4'h9, 4'h0, 1'b1, 1'b0, 1'b1};
                rows[2] = {16'hAAAA, 48'hfff0_00ff_f000, 48'h0f0f_0f0f_0f0f,
                           8'hFF, 8'hFF, 8'hFF, 4'hF, 4'h0, 1'b1, 1'b1, 1'b1};
                rows[3] = {16'hFFFF, 48'h5a5a_5a5a_5a5a, 48'ha5a5_a5a5_a5a5,
                           8'hFF, 8'hFF, 8'hFF, 4'hF, 4'h0, 1'b1, 1'b1, 1'b1};
                rows[4] = {16'h5555, 48'h1111_2222_3333, 48'h4444_5555_6666,
                           8'h00, 8'h00, 8'h7F, 4'h6, 4'hA, 1'b0, 1'b1, 1'b0};
                rows[5] = {16'hE44E, 48'h0123_4567_89ab, 48'hba98_7654_3210,
                           8'hC3, 8'h5A, 8'hF0, 4'h5, 4'h3, 1'b1, 1'b0, 1'b1};
                idx = N_DIRECTED;
                for (int i = 0; i < N_RANDOM; i++)
                begin
                        rows[idx]                = random_row(16'h0000);
                        rows[idx + N_RANDOM]     = random_row(16'h5555);
                        rows[idx + 2 * N_RANDOM] = random_row(16'($urandom()));
                        idx++;
                end
        endtask

        task automatic apply_row(input stim_t r);
                pad_mux  = r.mux;
                pad_cfg  = r.pcfg;
                gpio_cfg = r.gcfg;
                gpio_out = r.gout;
                gpio_dir = r.gdir;
                pad_in   = r.pin;
                spi_sdo  = r.sdo;
                spi_oen  = r.oen;
                spi_clk  = r.sclk;
                spi_csn  = r.csn;
                uart_tx  = r.utx;
        endtask

        // ************************************************************
        // Main sequence
        // ************************************************************

        initial
        begin
                void'($urandom(32'h51bc_0b23));
                arst_n = 1'b0;
                // Every pad held disabled during reset
                apply_row({16'hAAAA, 48'h0, 48'h0, 8'h0, 8'h0, 8'h0, 4'h0, 4'hF, 1'b0, 1'b1, 1'b1});
                build_table();
                repeat (RST_CYCLES) @(posedge ref_clk);
                @(negedge ref_clk);
                arst_n = 1'b1;
                while (!rst_n)
                        @(negedge ref_clk);
                for (int i = 0; i < N_ROWS; i++)
                begin
                        @(negedge ref_clk);
                        apply_row(rows[i]);
                end
                repeat (8) @(posedge ref_clk);
                #2;
                $display("Errors: %0d", err_count);
                if (err_count == 0)
                        $display("Test completed successfully");
                else
                        $display("Test failed");
                $finish;
        end

        initial
        begin
                #((RST_CYCLES + N_ROWS + 100) * CLK_PERIOD);
                $display("Timeout: the run did not finish in time, errors so far %0d", err_count);
                $display("Test failed");
                $finish;
        end

endmodule

//--- flist.f
safe_domain_pkg.sv
rst_sync.sv
slow_clk_gen.sv
pad_out_mux.sv
pad_in_demux.sv
safe_domain.sv
safe_domain_checker.sv
safe_domain_assert.sv
tb_safe_domain.sv

//--- Makefile
# Verilator build and run for the safe domain testbench

VERILATOR ?= verilator
TOP       ?= tb_safe_domain
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
PASS_MSG  ?= Test completed successfully

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
